// ==== verilog/bomb_audio_pkg.sv ====
`default_nettype none

package bomb_audio_pkg;

  // one game second, scaled down for simulation
  localparam int unsigned SEC_CYCLES = 2000;
  localparam int unsigned HALF_CYCLES = SEC_CYCLES / 2;
  localparam int unsigned QTR_CYCLES = SEC_CYCLES / 4;
  localparam int unsigned SEC_W = $clog2(SEC_CYCLES);

  // order of the enum is also the output priority, error first
  typedef enum logic [1:0] {
    SND_ERROR,
    SND_BOOM,
    SND_PUZZLE,
    SND_TICK
  } sound_e;

  localparam int unsigned NUM_SOUNDS = 4;

  // clock cycles between audio toggles, indexed by sound_e
  localparam int unsigned HALF_PERIOD [NUM_SOUNDS] = '{12, 30, 10, 7};
  // toggles per sound, even so every sound ends low
  localparam int unsigned TOGGLES [NUM_SOUNDS] = '{20, 40, 16, 8};

  function automatic int unsigned max4(input int unsigned a, input int unsigned b,
                                       input int unsigned c, input int unsigned d);
    int unsigned m;
    m = (a > b) ? a : b;
    m = (c > m) ? c : m;
    m = (d > m) ? d : m;
    return m;
  endfunction

  // counter widths cover the largest table entry
  localparam int unsigned HP_CNT_W =
    $clog2(max4(HALF_PERIOD[0], HALF_PERIOD[1], HALF_PERIOD[2], HALF_PERIOD[3]) + 1);
  localparam int unsigned TOG_CNT_W =
    $clog2(max4(TOGGLES[0], TOGGLES[1], TOGGLES[2], TOGGLES[3]) + 1);

  typedef enum logic {
    CH_IDLE,
    CH_PLAY
  } chan_state_e;

  // mm:ss as minutes, tens of seconds, ones of seconds
  typedef struct packed {
    logic [2:0] minutes;
    logic [2:0] sec_tens;
    logic [3:0] sec_ones;
  } game_time_t;

  // wrap values of the mixed-radix seconds digits
  localparam logic [3:0] ONES_MAX = 4'd9;
  localparam logic [2:0] TENS_MAX = 3'd5;

  typedef struct packed {
    logic active;
    logic tone;
  } chan_out_t;

  typedef struct packed {
    logic sec;
    logic half;
    logic quarter;
  } tick_strobes_t;

  // seconds-tens thresholds for the faster tick rates
  localparam logic [2:0] FAST_TENS = 3'd3;
  localparam logic [2:0] FASTER_TENS = 3'd1;

endpackage

`default_nettype wire

// ==== verilog/strobe_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module strobe_gen
  import bomb_audio_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   nrst,
  output tick_strobes_t strobes
);

  // free-running cycle counter, one game second per lap
  logic [SEC_W-1:0] cnt;
  logic at_sec;
  logic at_half;
  logic at_qtr;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      cnt <= '0;
    end else if (cnt == SEC_W'(SEC_CYCLES - 1)) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // decode points on the same counter
  // so all three rates stay phase-aligned
  always_comb begin
    at_sec = (cnt == SEC_W'(SEC_CYCLES - 1));
    // half rate also fires on every sec point
    at_half = at_sec || (cnt == SEC_W'(HALF_CYCLES - 1));
    // quarter rate covers the half points plus two more
    at_qtr = at_half ||
             (cnt == SEC_W'(QTR_CYCLES - 1)) ||
             (cnt == SEC_W'(3 * QTR_CYCLES - 1));
  end

  // registered so each strobe is a clean one-cycle pulse
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      strobes <= '0;
    end else begin
      strobes.sec     <= at_sec;
      strobes.half    <= at_half;
      strobes.quarter <= at_qtr;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/countdown_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module countdown_timer
  import bomb_audio_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        nrst,
  input  wire logic        tick,
  input  wire logic        start,
  input  wire game_time_t  load_time,
  output game_time_t       time_left,
  output logic             running,
  output logic             expired
);

  game_time_t dec_time;
  logic dec_zero;
  // high for one cycle right after time_left lands on zero
  logic zero_hit;

  // mixed-radix decrement of mm:ss
  always_comb begin
    dec_time = time_left;
    if (time_left.sec_ones != 4'd0) begin
      dec_time.sec_ones = time_left.sec_ones - 4'd1;
    end else begin
      dec_time.sec_ones = ONES_MAX;
      if (time_left.sec_tens != 3'd0) begin
        dec_time.sec_tens = time_left.sec_tens - 3'd1;
      end else begin
        // borrow from minutes
        dec_time.sec_tens = TENS_MAX;
        dec_time.minutes  = time_left.minutes - 3'd1;
      end
    end
  end

  // next value would be 0:00
  assign dec_zero = (dec_time == '0);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      time_left <= '0;
      running   <= 1'b0;
      zero_hit  <= 1'b0;
      expired   <= 1'b0;
    end else begin
      // expiry pulse trails the zero value by one cycle
      expired  <= zero_hit;
      zero_hit <= 1'b0;
      if (start) begin
        // start also reloads a timer that is already running
        time_left <= load_time;
        // a zero load has nothing to count
        running   <= (load_time != '0);
      end else if (running && tick) begin
        time_left <= dec_time;
        if (dec_zero) begin
          running  <= 1'b0;
          zero_hit <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tone_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

module tone_channel
  import bomb_audio_pkg::*;
#(
  parameter sound_e sound = SND_TICK
) (
  input  wire logic clk,
  input  wire logic nrst,
  input  wire logic trig,
  output chan_out_t chan
);

  chan_state_e state;
  // cycles since the last toggle
  logic [HP_CNT_W-1:0] hp_cnt;
  // toggles done so far in this burst
  logic [TOG_CNT_W-1:0] tog_cnt;
  logic tone;
  logic hp_done;
  logic last_toggle;

  // toggle point and final toggle, from the table row of this sound
  assign hp_done     = (hp_cnt == HP_CNT_W'(HALF_PERIOD[sound] - 1));
  assign last_toggle = (tog_cnt == TOG_CNT_W'(TOGGLES[sound] - 1));

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      state   <= CH_IDLE;
      hp_cnt  <= '0;
      tog_cnt <= '0;
      tone    <= 1'b0;
    end else if (trig) begin
      // start or restart the burst
      // count starts at 1 so the first rise lands HALF_PERIOD after the trigger
      state   <= CH_PLAY;
      hp_cnt  <= HP_CNT_W'(1);
      tog_cnt <= '0;
      tone    <= 1'b0;
    end else begin
      case (state)
        CH_IDLE: begin
          hp_cnt  <= '0;
          tog_cnt <= '0;
          tone    <= 1'b0;
        end
        CH_PLAY: begin
          if (hp_done) begin
            hp_cnt <= '0;
            if (last_toggle) begin
              // burst over, park low
              state   <= CH_IDLE;
              tog_cnt <= '0;
              tone    <= 1'b0;
            end else begin
              tog_cnt <= tog_cnt + 1'b1;
              tone    <= ~tone;
            end
          end else begin
            hp_cnt <= hp_cnt + 1'b1;
          end
        end
        default: begin
          state <= CH_IDLE;
        end
      endcase
    end
  end

  assign chan.active = (state == CH_PLAY);
  assign chan.tone   = tone;

endmodule

`default_nettype wire

// ==== verilog/audio_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module audio_sequencer
  import bomb_audio_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          nrst,
  input  wire tick_strobes_t strobes,
  input  wire game_time_t    time_left,
  input  wire logic          running,
  input  wire logic          expired,
  input  wire logic          wrong_move,
  input  wire logic          module_cleared,
  output logic               audio
);

  logic tick_sel;
  logic last_minute;
  // trigger vectors indexed by sound_e
  logic [NUM_SOUNDS-1:0] trig_d;
  logic [NUM_SOUNDS-1:0] trig_q;
  chan_out_t chans [NUM_SOUNDS];
  logic sel_tone;

  assign last_minute = (time_left.minutes == 3'd0);

  // tick rate from time left
  // quarter below 0:20, half below 0:40, else once a second
  always_comb begin
    if (last_minute && (time_left.sec_tens <= FASTER_TENS)) begin
      tick_sel = strobes.quarter;
    end else if (last_minute && (time_left.sec_tens <= FAST_TENS)) begin
      tick_sel = strobes.half;
    end else begin
      tick_sel = strobes.sec;
    end
  end

  always_comb begin
    trig_d             = '0;
    trig_d[SND_ERROR]  = wrong_move;
    // boom comes from timer expiry
    trig_d[SND_BOOM]   = expired;
    trig_d[SND_PUZZLE] = module_cleared;
    // no ticks once the timer stops
    trig_d[SND_TICK]   = tick_sel && running;
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      trig_q <= '0;
    end else begin
      trig_q <= trig_d;
    end
  end

  // one channel per sound, each keeps running even when it loses the output
  for (genvar g = 0; g < NUM_SOUNDS; g++) begin : g_chan
    tone_channel #(
      .sound (sound_e'(g))
    ) chan_i (
      .clk  (clk),
      .nrst (nrst),
      .trig (trig_q[g]),
      .chan (chans[g])
    );
  end

  // fixed priority, lowest index wins
  // scan from the bottom so the top active channel is assigned last
  always_comb begin
    sel_tone = 1'b0;
    for (int i = NUM_SOUNDS - 1; i >= 0; i--) begin
      if (chans[i].active) begin
        sel_tone = chans[i].tone;
      end
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      audio <= 1'b0;
    end else begin
      audio <= sel_tone;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bomb_audio_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bomb_audio_top
  import bomb_audio_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       nrst,
  input  wire logic       start,
  input  wire game_time_t load_time,
  input  wire logic       wrong_move,
  input  wire logic       module_cleared,
  output logic            audio,
  output game_time_t      time_left,
  output logic            running
);

  tick_strobes_t strobes;
  logic expired;

  // sec, half and quarter pulses off one counter
  strobe_gen strobe_i (
    .clk     (clk),
    .nrst    (nrst),
    .strobes (strobes)
  );

  // only the one-second strobe moves the clock
  countdown_timer timer_i (
    .clk       (clk),
    .nrst      (nrst),
    .tick      (strobes.sec),
    .start     (start),
    .load_time (load_time),
    .time_left (time_left),
    .running   (running),
    .expired   (expired)
  );

  audio_sequencer seq_i (
    .clk            (clk),
    .nrst           (nrst),
    .strobes        (strobes),
    .time_left      (time_left),
    .running        (running),
    .expired        (expired),
    .wrong_move     (wrong_move),
    .module_cleared (module_cleared),
    .audio          (audio)
  );

endmodule

`default_nettype wire

// ==== sim/tb_bomb_audio.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bomb_audio
  import bomb_audio_pkg::*;
();

  localparam int NUM_CASES = 5;
  // edges further apart than this belong to different bursts
  localparam int BURST_GAP = 200;
  // low time that marks the end of a sound
  localparam int QUIET_CYCLES = 400;

  typedef enum int {
    EV_NONE,
    EV_WRONG,
    EV_CLEARED,
    EV_START,
    EV_BOOM_WRONG
  } event_e;

  logic clk;
  logic nrst;
  logic start;
  game_time_t load_time;
  logic wrong_move;
  logic module_cleared;
  logic audio;
  game_time_t time_left;
  logic running;

  // case table, load time in seconds and -1 for none
  string case_name [NUM_CASES] = '{"idle", "wrong_move", "module_cleared",
                                   "countdown", "error_over_boom"};
  int case_load [NUM_CASES] = '{-1, -1, -1, 45, 1};
  event_e case_event [NUM_CASES] = '{EV_NONE, EV_WRONG, EV_CLEARED, EV_START, EV_BOOM_WRONG};
  int case_tog [NUM_CASES] = '{0, TOGGLES[SND_ERROR], TOGGLES[SND_PUZZLE],
                               TOGGLES[SND_TICK], TOGGLES[SND_ERROR]};
  int case_hp [NUM_CASES] = '{0, HALF_PERIOD[SND_ERROR], HALF_PERIOD[SND_PUZZLE],
                              HALF_PERIOD[SND_TICK], HALF_PERIOD[SND_ERROR]};

  // edge log, cycle of each audio edge and the seconds left then
  int cyc;
  int edge_cyc [$];
  int edge_secs [$];
  logic audio_prev;
  int err_cnt;
  int timeout_cnt;
  int seed;
  int gap;

  bomb_audio_top dut_i (
    .clk            (clk),
    .nrst           (nrst),
    .start          (start),
    .load_time      (load_time),
    .wrong_move     (wrong_move),
    .module_cleared (module_cleared),
    .audio          (audio),
    .time_left      (time_left),
    .running        (running)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int to_secs(input game_time_t t);
    return 60 * int'(t.minutes) + 10 * int'(t.sec_tens) + int'(t.sec_ones);
  endfunction

  function automatic game_time_t from_secs(input int s);
    game_time_t t;
    t.minutes  = 3'(s / 60);
    t.sec_tens = 3'((s % 60) / 10);
    t.sec_ones = 4'(s % 10);
    return t;
  endfunction

  // tick spacing for a given time left
  // full second above 0:40, half from 0:39, quarter from 0:19
  function automatic int tick_gap(input int secs);
    if (secs >= 40) begin
      return SEC_CYCLES;
    end else if (secs >= 20) begin
      return SEC_CYCLES / 2;
    end
    return SEC_CYCLES / 4;
  endfunction

  // one clock step, sampled on the falling edge where outputs are stable
  task automatic next_cycle();
    @(negedge clk);
    cyc++;
    if (audio !== audio_prev) begin
      edge_cyc.push_back(cyc);
      edge_secs.push_back(to_secs(time_left));
      audio_prev = audio;
    end
  endtask

  task automatic check_value(input string name, input string what, input int exp, input int act);
    assert (act == exp) else begin
      err_cnt++;
      $display("ERR %s: %s expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic check_min(input string name, input string what, input int exp, input int act);
    assert (act >= exp) else begin
      err_cnt++;
      $display("ERR %s: %s expected at least %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    timeout_cnt++;
    $display("%s: gave up waiting for %s", name, what);
  endtask

  // one-cycle pulse on the chosen inputs
  task automatic pulse_inputs(input logic st, input logic wm, input logic mc);
    start          = st;
    wrong_move     = wm;
    module_cleared = mc;
    next_cycle();
    start          = 1'b0;
    wrong_move     = 1'b0;
    module_cleared = 1'b0;
  endtask

  // wait for an edge at index first or later, then for a quiet output
  task automatic wait_quiet(input string name, input int first, input int limit);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    while (!done && n < limit) begin
      next_cycle();
      n++;
      if (edge_cyc.size() > first) begin
        done = (cyc - edge_cyc[$] >= QUIET_CYCLES);
      end
    end
    if (!done) begin
      report_timeout(name, "the sound to end");
    end
  endtask

  // edges first..last-1 form one burst
  task automatic check_burst(input string name, input int first, input int last,
                             input int tog, input int hp);
    check_value(name, "edge count", tog, last - first);
    for (int i = first + 1; i < last; i++) begin
      check_value(name, "edge spacing", hp, edge_cyc[i] - edge_cyc[i-1]);
    end
  endtask

  task automatic run_countdown(input int idx, input int base);
    string name;
    int n;
    int prev_secs;
    int last_change;
    int first;
    int exp_ticks;
    int bursts [$];
    name = case_name[idx];
    pulse_inputs(1'b1, 1'b0, 1'b0);
    check_value(name, "running after start", 1, int'(running));
    check_value(name, "time_left after start", case_load[idx], to_secs(time_left));
    prev_secs = to_secs(time_left);
    last_change = 0;
    n = 0;
    // follow the countdown, one second per SEC_CYCLES
    while (running && n < 60 * SEC_CYCLES) begin
      next_cycle();
      n++;
      if (to_secs(time_left) != prev_secs) begin
        check_value(name, "time_left", prev_secs - 1, to_secs(time_left));
        if (last_change > 0) begin
          check_value(name, "cycles per second", SEC_CYCLES, cyc - last_change);
        end
        last_change = cyc;
        prev_secs = to_secs(time_left);
      end
    end
    if (running) begin
      report_timeout(name, "the timer to expire");
    end
    check_value(name, "time_left at expiry", 0, to_secs(time_left));
    // boom brings new edges after the fall of running
    wait_quiet(name, edge_cyc.size(), 4 * SEC_CYCLES);
    // split the log into bursts, end marker last
    bursts.push_back(base);
    for (int i = base + 1; i < edge_cyc.size(); i++) begin
      if (edge_cyc[i] - edge_cyc[i-1] > BURST_GAP) begin
        bursts.push_back(i);
      end
    end
    bursts.push_back(edge_cyc.size());
    // tick on every second left, the one at zero hidden under the boom
    exp_ticks = 0;
    for (int t = 1; t < case_load[idx]; t++) begin
      exp_ticks += SEC_CYCLES / tick_gap(t);
    end
    check_value(name, "tick bursts", exp_ticks, bursts.size() - 2);
    for (int b = 0; b + 2 < bursts.size(); b++) begin
      check_burst(name, bursts[b], bursts[b+1], case_tog[idx], case_hp[idx]);
      if (b + 3 < bursts.size()) begin
        check_value(name, "tick gap", tick_gap(edge_secs[bursts[b]]),
                    edge_cyc[bursts[b+1]] - edge_cyc[bursts[b]]);
      end
    end
    // last burst is the boom
    check_burst(name, bursts[bursts.size()-2], bursts[bursts.size()-1],
                TOGGLES[SND_BOOM], HALF_PERIOD[SND_BOOM]);
    // nothing more once the timer has stopped
    first = edge_cyc.size();
    repeat (2 * SEC_CYCLES) next_cycle();
    check_value(name, "edges after boom", 0, edge_cyc.size() - first);
  endtask

  task automatic run_boom_error(input int idx);
    string name;
    int n;
    int first;
    int run;
    int best;
    name = case_name[idx];
    load_time = from_secs(case_load[idx]);
    pulse_inputs(1'b1, 1'b0, 1'b0);
    n = 0;
    while (running && n < 4 * SEC_CYCLES) begin
      next_cycle();
      n++;
    end
    if (running) begin
      report_timeout(name, "the timer to expire");
    end
    first = edge_cyc.size();
    // a few boom edges before the wrong move
    n = 0;
    while (edge_cyc.size() < first + 4 && n < SEC_CYCLES) begin
      next_cycle();
      n++;
    end
    if (edge_cyc.size() < first + 4) begin
      report_timeout(name, "the boom to start");
    end
    pulse_inputs(1'b0, 1'b1, 1'b0);
    wait_quiet(name, first, 4 * SEC_CYCLES);
    check_value(name, "spacing before error", HALF_PERIOD[SND_BOOM],
                edge_cyc[first+1] - edge_cyc[first]);
    // longest run of error spacing
    run = 0;
    best = 0;
    for (int i = first + 1; i < edge_cyc.size(); i++) begin
      if (edge_cyc[i] - edge_cyc[i-1] == case_hp[idx]) begin
        run++;
        best = (run > best) ? run : best;
      end else begin
        run = 0;
      end
    end
    // first and last error edge may merge with the boom tone
    check_min(name, "error spacing run", case_tog[idx] - 2, best);
    check_value(name, "spacing after error", HALF_PERIOD[SND_BOOM],
                edge_cyc[edge_cyc.size()-1] - edge_cyc[edge_cyc.size()-2]);
  endtask

  task automatic run_case(input int idx);
    string name;
    int base;
    name = case_name[idx];
    if (case_load[idx] >= 0) begin
      load_time = from_secs(case_load[idx]);
    end
    base = edge_cyc.size();
    case (case_event[idx])
      EV_NONE: begin
        // timer stopped, so no ticks either
        repeat (3 * SEC_CYCLES) next_cycle();
        check_value(name, "edge count", case_tog[idx], edge_cyc.size() - base);
        check_value(name, "running", 0, int'(running));
      end
      EV_WRONG, EV_CLEARED: begin
        pulse_inputs(1'b0, case_event[idx] == EV_WRONG, case_event[idx] == EV_CLEARED);
        wait_quiet(name, base, SEC_CYCLES);
        check_burst(name, base, edge_cyc.size(), case_tog[idx], case_hp[idx]);
      end
      EV_START: begin
        run_countdown(idx, base);
      end
      EV_BOOM_WRONG: begin
        run_boom_error(idx);
      end
    endcase
    check_value(name, "final audio", 0, int'(audio));
  endtask

  initial begin
    seed = 32'hfc45_0630;
    nrst = 1'b0;
    start = 1'b0;
    load_time = '0;
    wrong_move = 1'b0;
    module_cleared = 1'b0;
    cyc = 0;
    audio_prev = 1'b0;
    err_cnt = 0;
    timeout_cnt = 0;
    repeat (16) next_cycle();
    nrst = 1'b1;
    next_cycle();
    check_value("reset", "audio", 0, int'(audio));
    check_value("reset", "running", 0, int'(running));
    check_value("reset", "time_left", 0, to_secs(time_left));
    for (int i = 0; i < NUM_CASES; i++) begin
      // random idle gap shifts the strobe phase
      gap = 20 + ($random(seed) & 32'hff);
      repeat (gap) next_cycle();
      run_case(i);
    end
    $display("errors: %0d wrong values, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/bomb_audio_pkg.sv
verilog/strobe_gen.sv
verilog/countdown_timer.sv
verilog/tone_channel.sv
verilog/audio_sequencer.sv
verilog/bomb_audio_top.sv
sim/tb_bomb_audio.sv

// ==== Makefile ====
# Verilator build and run of the bomb audio testbench

TOP := tb_bomb_audio
BIN := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): vlog.f $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

# output goes to the terminal, the status comes from the search
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -x 'sim passed' > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module bomb_audio_top -f vlog.f

clean:
	rm -rf obj_dir
